// File: verilog.f
+incdir+bench
hdl/sgd_pkg.sv
hdl/sgd_fifo.sv
hdl/bitplane_dot.sv
hdl/gradient_update.sv
hdl/model_store.sv
hdl/sgd_engine.sv
bench/sgd_engine_tb.sv

// File: Makefile
# Verilator build and run of the SGD engine testbench
VERILATOR ?= verilator
TOP       ?= sgd_engine_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= STATUS: PASS

SOURCES := $(wildcard hdl/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/sgd_input.dat
// per sample: plane0 plane1 plane2 plane3 loss (msb plane first, bit j is feature j)
// last block: expected final model x[0] .. x[7] as signed 32-bit words
// sample 0, features 1 2 3 4 5 6 7 8
80 78 66 55 00000001
// sample 1, features 8 0 1 0 2 0 3 0
01 00 50 44 FFFFFFFE
// sample 2, features 15 1 0 2 0 3 0 4
01 81 29 23 00000003
// sample 3, features 0 0 0 0 1 1 1 1
00 00 00 F0 FFFFFFFF
// sample 4, all features 2
00 00 FF 00 00000002
// sample 5, features 5 0 5 0 5 0 5 0
00 55 00 55 FFFFFFFF
// expected final model
FFFFFFE3
FFFFFFF7
00000000
FFFFFFF2
00000001
FFFFFFEE
00000001
FFFFFFE9

// File: bench/sgd_ref_model.svh
// reference dot product and model update for bit-plane samples,
// and the LCG for idle gaps and loss delays
`ifndef SGD_REF_MODEL_SVH
`define SGD_REF_MODEL_SVH

// one sample, entry 0 is the msb plane
typedef plane_t [NUM_BITS-1:0] sample_t;

int unsigned lcg_state = 32'd66320;

// next pseudo random value, upper bits only
function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

// feature j rebuilt from its bit in every plane, msb plane first
function automatic int unsigned feature_of(sample_t planes, int j);
    int unsigned f;
    f = 0;
    for (int p = 0; p < NUM_BITS; p++)
    begin
        f = (f << 1) | 32'(planes[p][j]);
    end
    return f;
endfunction

// sum of x[j] times feature j, wraps in 32 bits
function automatic dot_t expected_dot(x_vec_t x, sample_t planes);
    dot_t sum;
    sum = '0;
    for (int j = 0; j < DIM; j++)
        sum = sum + x[j] * dot_t'(feature_of(planes, j));
    return sum;
endfunction

// x[j] minus loss times feature j
function automatic x_vec_t updated_model(x_vec_t x, sample_t planes, loss_t loss);
    x_vec_t nx;
    nx = x;
    for (int j = 0; j < DIM; j++)
        nx[j] = x[j] - loss * x_word_t'(feature_of(planes, j));
    return nx;
endfunction

`endif

// File: bench/sgd_engine_tb.sv
// testbench for the SGD engine, plane and loss drivers,
// dot and model checks, watchdog and per-test reporting
`timescale 1ns/100ps

module sgd_engine_tb
    import sgd_pkg::*;
();

    localparam int NUM_SAMPLES      = 6;
    localparam int PACED_SAMPLES    = 2;
    localparam int WORDS_PER_SAMPLE = NUM_BITS + 1;
    localparam int STIM_WORDS       = NUM_SAMPLES * WORDS_PER_SAMPLE + DIM;
    localparam int CLK_PERIOD       = 10;
    localparam int WATCHDOG_CYCLES  = NUM_SAMPLES * 200 + 200;

    `include "sgd_ref_model.svh"

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  plane_valid;
    plane_t                plane_data;
    logic                  plane_almost_full;
    logic                  loss_valid;
    loss_t                 loss_data;
    logic                  loss_almost_full;
    logic                  dot_valid;
    dot_t                  dot_data;
    logic [ADDR_WIDTH-1:0] x_rd_addr;
    x_word_t               x_rd_data;

    // stimulus image and what the host knows
    logic [31:0] stim_mem [STIM_WORDS];
    sample_t     samples [NUM_SAMPLES];
    loss_t       losses [NUM_SAMPLES];
    x_vec_t      expected_final;
    x_vec_t      model_ref;
    dot_t        dot_got [NUM_SAMPLES];

    int dots_seen     = 0;
    int losses_sent   = 0;
    int updates_count = 0;
    int main_errors   = 0;
    int mon_errors    = 0;
    int dot_errors    = 0;

    sgd_engine sgd_engine_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int total_errors();
        return main_errors + mon_errors + dot_errors;
    endfunction

    ////////////////////////////////////////
    // host side helpers enter and leave 1 ns after an edge
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // hold off while the plane FIFO is almost full
    task automatic push_plane(input plane_t word);
        while (plane_almost_full)
        begin
            plane_valid = 1'b0;
            @(posedge clk);
            #1;
        end
        plane_valid = 1'b1;
        plane_data  = word;
        @(posedge clk);
        #1;
        plane_valid = 1'b0;
    endtask

    task automatic write_sample(input int s, input bit gaps);
        for (int p = 0; p < NUM_BITS; p++)
        begin
            if (gaps)
                idle_cycles(next_random() % 4);
            push_plane(samples[s][p]);
        end
    endtask

    // update_done pulses are the end of each sample
    task automatic wait_updates(input int n);
        while (updates_count < n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    // data comes two edges after the address
    task automatic read_word(input int j, output x_word_t value);
        x_rd_addr = ADDR_WIDTH'(j);
        repeat (2) @(posedge clk);
        #1;
        value = x_rd_data;
    endtask

    task automatic expect_level(input logic value, input logic expected, input string name);
        assert (value === expected)
        else
        begin
            main_errors++;
            $display("Fail at %0t ns: %s got %b expected %b", $time, name, value, expected);
        end
    endtask

    task automatic report_test(input string name, input int start);
        $display("test %s finished with %0d errors", name, total_errors() - start);
    endtask

    ////////////////////////////////////////
    // dot monitor sees one result per sample
    always @(negedge clk)
    begin
        if (rst_n && dot_valid)
        begin
            assert (dots_seen < NUM_SAMPLES)
            else
            begin
                mon_errors++;
                $display("Error at %0t ns: more dot products than samples", $time);
            end
            assert (losses_sent == dots_seen)
            else
            begin
                mon_errors++;
                $display("Error at %0t ns: dot product %0d came before loss %0d was sent",
                         $time, dots_seen, dots_seen - 1);
            end
            if (dots_seen < NUM_SAMPLES)
                dot_got[dots_seen] = dot_data;
            dots_seen = dots_seen + 1;
        end
    end

    always @(posedge clk)
    begin
        if (rst_n && sgd_engine_i.update_done)
            updates_count <= updates_count + 1;
    end

    ////////////////////////////////////////
    // host loss return checks each dot against the model so far
    initial
    begin : loss_return
        int unsigned delay;
        dot_t        expected;

        loss_valid = 1'b0;
        loss_data  = '0;
        model_ref  = '0;
        @(posedge rst_n);
        for (int s = 0; s < NUM_SAMPLES; s++)
        begin
            while (dots_seen <= s)
                @(posedge clk);
            expected = expected_dot(model_ref, samples[s]);
            assert (dot_got[s] == expected)
            else
            begin
                dot_errors++;
                $display("Fail at %0t ns: dot_data of sample %0d got %0d expected %0d",
                         $time, s, dot_got[s], expected);
            end
            model_ref = updated_model(model_ref, samples[s], losses[s]);
            delay = next_random() % 41;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            #1;
            loss_valid  = 1'b1;
            loss_data   = losses[s];
            losses_sent = losses_sent + 1;
            @(posedge clk);
            #1;
            loss_valid = 1'b0;
        end
    end

    initial
    begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Error: watchdog expired after %0d cycles, the run did not finish",
                 WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // test sequence
    initial
    begin : main_flow
        int      start;
        x_word_t got;

        rst_n       = 1'b0;
        plane_valid = 1'b0;
        plane_data  = '0;
        x_rd_addr   = '0;
        $readmemh("bench/sgd_input.dat", stim_mem);
        assert (!$isunknown(stim_mem[STIM_WORDS-1]))
        else
        begin
            main_errors++;
            $display("Error: bench/sgd_input.dat is missing or too short");
        end
        for (int s = 0; s < NUM_SAMPLES; s++)
        begin
            for (int p = 0; p < NUM_BITS; p++)
                samples[s][p] = stim_mem[s * WORDS_PER_SAMPLE + p][DIM-1:0];
            losses[s] = stim_mem[s * WORDS_PER_SAMPLE + NUM_BITS];
        end
        for (int j = 0; j < DIM; j++)
            expected_final[j] = stim_mem[NUM_SAMPLES * WORDS_PER_SAMPLE + j];
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // outputs quiet and model cleared
        start = total_errors();
        expect_level(dot_valid, 1'b0, "dot_valid");
        expect_level(plane_almost_full, 1'b0, "plane_almost_full");
        expect_level(loss_almost_full, 1'b0, "loss_almost_full");
        for (int j = 0; j < DIM; j++)
        begin
            read_word(j, got);
            assert (got == '0)
            else
            begin
                main_errors++;
                $display("Fail at %0t ns: x_rd_data[%0d] got %0d expected 0", $time, j, got);
            end
        end
        report_test("reset", start);

        // samples with random idle gaps between planes
        start = total_errors();
        for (int s = 0; s < PACED_SAMPLES; s++)
            write_sample(s, 1'b1);
        wait_updates(PACED_SAMPLES);
        report_test("paced", start);

        // back to back writes paused by almost-full
        start = total_errors();
        for (int s = PACED_SAMPLES; s < NUM_SAMPLES; s++)
            write_sample(s, 1'b0);
        // later samples wait behind the credit and leave only the margin free
        expect_level(plane_almost_full, 1'b1, "plane_almost_full");
        wait_updates(NUM_SAMPLES);
        assert (dots_seen == NUM_SAMPLES && losses_sent == NUM_SAMPLES)
        else
        begin
            main_errors++;
            $display("Error: %0d dot products and %0d losses for %0d samples",
                     dots_seen, losses_sent, NUM_SAMPLES);
        end
        report_test("burst", start);

        // final model through the host port
        start = total_errors();
        for (int j = 0; j < DIM; j++)
        begin
            read_word(j, got);
            assert (got == model_ref[j])
            else
            begin
                main_errors++;
                $display("Fail at %0t ns: x_rd_data[%0d] got %0d expected %0d",
                         $time, j, got, model_ref[j]);
            end
            assert (got == expected_final[j])
            else
            begin
                main_errors++;
                $display("Fail at %0t ns: x_rd_data[%0d] got %0d expected %0d from file",
                         $time, j, got, expected_final[j]);
            end
        end
        report_test("readout", start);

        $display("4 tests run, %0d errors", total_errors());
        if (total_errors() == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: hdl/sgd_engine.sv
// top level of the SGD engine, plane, replay and loss FIFOs
// around the dot product, gradient and model stages
`timescale 1ns/100ps

module sgd_engine
    import sgd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  plane_valid,
    input  plane_t                plane_data,
    output logic                  plane_almost_full,
    input  logic                  loss_valid,
    input  loss_t                 loss_data,
    output logic                  loss_almost_full,
    output logic                  dot_valid,
    output dot_t                  dot_data,
    input  logic [ADDR_WIDTH-1:0] x_rd_addr,
    output x_word_t               x_rd_data
);

    // plane FIFO to dot product
    logic   plane_pop;
    plane_t plane_word;
    logic   plane_word_valid;
    logic   plane_empty;
    // dot product to gradient, through replay
    logic   replay_push;
    plane_t replay_in;
    logic   replay_full;
    logic   replay_pop;
    plane_t replay_out;
    logic   replay_out_valid;
    logic   replay_empty;
    // losses from the host
    logic   loss_pop;
    loss_t  loss_word;
    logic   loss_word_valid;
    logic   loss_empty;
    // model
    x_vec_t x_vec;
    logic   x_wr_en;
    x_vec_t x_wr_vec;
    logic   update_done;

    ////////////////////////////////////////
    // buffers
    sgd_fifo #(.T_PAYLOAD(plane_t)) plane_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(plane_valid), .push_data(plane_data),
        .pop(plane_pop), .pop_data(plane_word), .pop_valid(plane_word_valid),
        .empty(plane_empty), .almost_full(plane_almost_full)
    );

    sgd_fifo #(.T_PAYLOAD(plane_t)) replay_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(replay_push), .push_data(replay_in),
        .pop(replay_pop), .pop_data(replay_out), .pop_valid(replay_out_valid),
        .empty(replay_empty), .almost_full(replay_full)
    );

    sgd_fifo #(.T_PAYLOAD(loss_t)) loss_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(loss_valid), .push_data(loss_data),
        .pop(loss_pop), .pop_data(loss_word), .pop_valid(loss_word_valid),
        .empty(loss_empty), .almost_full(loss_almost_full)
    );

    ////////////////////////////////////////
    // stages
    bitplane_dot bitplane_dot_i (
        .clk(clk), .rst_n(rst_n),
        .plane_empty(plane_empty), .plane_pop(plane_pop),
        .plane_word(plane_word), .plane_word_valid(plane_word_valid),
        .x_vec(x_vec),
        .replay_push(replay_push), .replay_word(replay_in), .replay_full(replay_full),
        .update_done(update_done),
        .dot_valid(dot_valid), .dot_data(dot_data)
    );

    gradient_update gradient_update_i (
        .clk(clk), .rst_n(rst_n),
        .loss_empty(loss_empty), .loss_pop(loss_pop),
        .loss_word(loss_word), .loss_word_valid(loss_word_valid),
        .replay_empty(replay_empty), .replay_pop(replay_pop),
        .replay_word(replay_out), .replay_word_valid(replay_out_valid),
        .x_vec(x_vec), .x_wr_en(x_wr_en), .x_wr_vec(x_wr_vec),
        .update_done(update_done)
    );

    model_store model_store_i (
        .clk(clk), .rst_n(rst_n),
        .x_wr_en(x_wr_en), .x_wr_vec(x_wr_vec), .x_vec(x_vec),
        .x_rd_addr(x_rd_addr), .x_rd_data(x_rd_data)
    );

endmodule

// File: hdl/model_store.sv
// model registers with a full vector read, one vector write
// and a two-cycle host read port
`timescale 1ns/100ps

module model_store
    import sgd_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  x_wr_en,
    input  x_vec_t                x_wr_vec,
    output x_vec_t                x_vec,
    input  logic [ADDR_WIDTH-1:0] x_rd_addr,
    output x_word_t               x_rd_data
);

    x_vec_t                x_reg;
    logic [ADDR_WIDTH-1:0] rd_addr_q;

    // model starts from zero
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            x_reg <= '0;
        else if (x_wr_en)
            x_reg <= x_wr_vec;
    end

    // both engines see the current registers
    assign x_vec = x_reg;

    ////////////////////////////////////////
    // host port, address then data register
    always_ff @(posedge clk)
    begin
        rd_addr_q <= x_rd_addr;
        x_rd_data <= x_reg[rd_addr_q];
    end

endmodule

// File: hdl/gradient_update.sv
// pairs a returned loss with the replayed planes and
// subtracts the plane-weighted loss from the selected model words
`timescale 1ns/100ps

module gradient_update
    import sgd_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   loss_empty,
    output logic   loss_pop,
    input  loss_t  loss_word,
    input  logic   loss_word_valid,
    input  logic   replay_empty,
    output logic   replay_pop,
    input  plane_t replay_word,
    input  logic   replay_word_valid,
    input  x_vec_t x_vec,
    output logic   x_wr_en,
    output x_vec_t x_wr_vec,
    output logic   update_done
);

    // busy from loss pop to the last write
    logic       loss_busy;
    logic       loss_held;
    loss_t      loss_reg;
    plane_idx_t pop_idx;
    logic       pops_done;
    plane_idx_t word_idx;
    logic       last_word;
    x_word_t    step;

    assign loss_pop   = !loss_empty && !loss_busy;
    assign replay_pop = loss_held && !replay_empty && !pops_done;
    assign last_word  = replay_word_valid && (word_idx == plane_idx_t'(NUM_BITS - 1));

    ////////////////////////////////////////
    // sample control
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            loss_busy   <= 1'b0;
            loss_held   <= 1'b0;
            pop_idx     <= '0;
            pops_done   <= 1'b0;
            word_idx    <= '0;
            update_done <= 1'b0;
        end
        else
        begin
            update_done <= last_word;
            if (loss_pop)
                loss_busy <= 1'b1;
            if (loss_word_valid)
                loss_held <= 1'b1;
            if (replay_pop)
            begin
                pop_idx <= (pop_idx == plane_idx_t'(NUM_BITS - 1)) ? '0 : pop_idx + 1'b1;
                if (pop_idx == plane_idx_t'(NUM_BITS - 1))
                    pops_done <= 1'b1;
            end
            if (replay_word_valid)
                word_idx <= (word_idx == plane_idx_t'(NUM_BITS - 1)) ? '0 : word_idx + 1'b1;
            // release for the next loss
            if (last_word)
            begin
                loss_busy <= 1'b0;
                loss_held <= 1'b0;
                pops_done <= 1'b0;
            end
        end
    end

    // loss payload
    always_ff @(posedge clk)
    begin
        if (loss_word_valid)
            loss_reg <= loss_word;
    end

    ////////////////////////////////////////
    // per-plane model write
    always_comb
    begin
        step     = weight_by_plane(loss_reg, word_idx);
        x_wr_vec = x_vec;
        for (int j = 0; j < DIM; j++)
        begin
            if (replay_word[j])
                x_wr_vec[j] = x_vec[j] - step;
        end
    end

    assign x_wr_en = replay_word_valid;

    // replayed plane lands while its loss is still held
    assert property (@(posedge clk) disable iff (!rst_n)
        replay_word_valid |-> loss_held);

endmodule

// File: hdl/bitplane_dot.sv
// bit-serial dot product of one sample against the model,
// with plane replay and the update credit
`timescale 1ns/100ps

module bitplane_dot
    import sgd_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   plane_empty,
    output logic   plane_pop,
    input  plane_t plane_word,
    input  logic   plane_word_valid,
    input  x_vec_t x_vec,
    output logic   replay_push,
    output plane_t replay_word,
    input  logic   replay_full,
    input  logic   update_done,
    output logic   dot_valid,
    output dot_t   dot_data
);

    // credit held from the first pop until the update is written
    logic       credit;
    logic       popping;
    plane_idx_t pop_idx;
    plane_idx_t word_idx;
    x_word_t    plane_sum;
    dot_t       sum_reg;
    plane_idx_t sum_idx;
    logic       sum_valid;
    dot_t       acc;

    ////////////////////////////////////////
    // pop side
    // a new sample only starts on a free credit
    assign plane_pop = !plane_empty && !replay_full && (popping || !credit);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            credit  <= 1'b0;
            popping <= 1'b0;
            pop_idx <= '0;
        end
        else
        begin
            if (update_done)
                credit <= 1'b0;
            if (plane_pop)
            begin
                pop_idx <= (pop_idx == plane_idx_t'(NUM_BITS - 1)) ? '0 : pop_idx + 1'b1;
                if (!popping)
                begin
                    credit  <= 1'b1;
                    popping <= 1'b1;
                end
                if (pop_idx == plane_idx_t'(NUM_BITS - 1))
                    popping <= 1'b0;
            end
        end
    end

    // every used plane goes on to the gradient stage
    assign replay_push = plane_word_valid;
    assign replay_word = plane_word;

    ////////////////////////////////////////
    // stage 1, model words selected by the plane
    always_comb
    begin
        plane_sum = '0;
        for (int j = 0; j < DIM; j++)
        begin
            if (plane_word[j])
                plane_sum = plane_sum + x_vec[j];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            word_idx  <= '0;
            sum_valid <= 1'b0;
        end
        else
        begin
            sum_valid <= plane_word_valid;
            if (plane_word_valid)
                word_idx <= (word_idx == plane_idx_t'(NUM_BITS - 1)) ? '0 : word_idx + 1'b1;
        end
    end

    // plane sum payload
    always_ff @(posedge clk)
    begin
        if (plane_word_valid)
        begin
            sum_reg <= plane_sum;
            sum_idx <= word_idx;
        end
    end

    ////////////////////////////////////////
    // stage 2, weighted accumulate
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            acc       <= '0;
            dot_valid <= 1'b0;
        end
        else
        begin
            dot_valid <= sum_valid && (sum_idx == plane_idx_t'(NUM_BITS - 1));
            if (sum_valid)
            begin
                // first plane restarts the sum
                if (sum_idx == '0)
                    acc <= weight_by_plane(sum_reg, sum_idx);
                else
                    acc <= acc + weight_by_plane(sum_reg, sum_idx);
            end
        end
    end

    assign dot_data = acc;

    // gradient stage only finishes a sample this stage started
    assert property (@(posedge clk) disable iff (!rst_n) update_done |-> credit);

endmodule

// File: hdl/sgd_fifo.sv
// synchronous FIFO with a typed payload, registered almost-full
// and read data valid one cycle after the pop
`timescale 1ns/100ps

module sgd_fifo
    import sgd_pkg::*;
#(
    parameter type T_PAYLOAD = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  T_PAYLOAD push_data,
    input  logic     pop,
    output T_PAYLOAD pop_data,
    output logic     pop_valid,
    output logic     empty,
    output logic     almost_full
);

    T_PAYLOAD                   mem [FIFO_DEPTH];
    logic [FIFO_DEPTH_BITS-1:0] wr_ptr;
    logic [FIFO_DEPTH_BITS-1:0] rd_ptr;
    logic [FIFO_DEPTH_BITS:0]   count;
    logic [FIFO_DEPTH_BITS:0]   count_next;
    logic                       full;

    assign empty = (count == '0);
    assign full  = (count == (FIFO_DEPTH_BITS+1)'(FIFO_DEPTH));

    // occupancy after this edge
    always_comb
    begin
        count_next = count;
        if (push)
            count_next = count_next + 1'b1;
        if (pop)
            count_next = count_next - 1'b1;
    end

    ////////////////////////////////////////
    // pointers, count, flags
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            pop_valid   <= 1'b0;
            almost_full <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count     <= count_next;
            pop_valid <= pop;
            // raised with MARGIN or fewer free slots left
            almost_full <= (FIFO_DEPTH - int'(count_next)) <= ALMOST_FULL_MARGIN;
        end
    end

    // storage and read register
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_data;
        if (pop)
            pop_data <= mem[rd_ptr];
    end

    // producer must respect the almost-full margin
    assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    // consumer must look at empty
    assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

// File: hdl/sgd_pkg.sv
// sizes, payload types and plane weight helpers
// shared by the bit-serial SGD datapath

package sgd_pkg;

    ////////////////////////////////////////
    // problem size
    localparam int DIM      = 8;
    localparam int NUM_BITS = 4;
    localparam int X_WIDTH  = 32;

    // host readout address, log2(DIM)
    localparam int ADDR_WIDTH = 3;

    // FIFO sizing
    localparam int FIFO_DEPTH_BITS    = 4;
    localparam int FIFO_DEPTH         = 1 << FIFO_DEPTH_BITS;
    localparam int ALMOST_FULL_MARGIN = 4;

    ////////////////////////////////////////
    // payloads
    // bit j of a plane word belongs to feature j
    typedef logic [DIM-1:0]                plane_t;
    typedef logic [1:0]                    plane_idx_t;
    typedef logic signed [X_WIDTH-1:0]     x_word_t;
    typedef x_word_t [DIM-1:0]             x_vec_t;
    typedef logic signed [31:0]            loss_t;
    typedef logic signed [31:0]            dot_t;

    // planes arrive msb first, so plane 0 carries the largest weight
    function automatic plane_idx_t plane_shift(plane_idx_t idx);
        return plane_idx_t'(NUM_BITS - 1) - idx;
    endfunction

    // value scaled by the weight of its plane, wraps in 32 bits
    function automatic x_word_t weight_by_plane(x_word_t value, plane_idx_t idx);
        return value <<< plane_shift(idx);
    endfunction

endpackage
